// ==== md_consts.svh ====
`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// Operand and result width, one word
`define MD_WIDTH 32

// Iteration counter width
`define MD_CNT_W 5

// Counter start value, one step per bit after the first
`define MD_ITER_LAST 31

`endif

// ==== md_pkg.sv ====
package md_pkg;

	// Operation select, matches the core decoder encoding
	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,
		MD_OP_MULH = 2'd1,
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	// Sequencer states
	typedef enum logic [2:0] {
		MD_IDLE, MD_ABS_A, MD_ABS_B, MD_COMP,
		MD_LAST, MD_CHANGE_SIGN, MD_FINISH
	} md_state_e;

endpackage

// ==== md_fsm.sv ====
`timescale 1ns/1ps
`include "md_consts.svh"

module md_fsm (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  mult_en_i,
	input  logic                  div_en_i,
	input  md_pkg::md_op_e        operator_i,
	input  logic [`MD_WIDTH-1:0]  op_b_i,
	output md_pkg::md_state_e     state_o,
	output logic [`MD_CNT_W-1:0]  iter_cnt_o,
	output logic                  valid_o
);
	import md_pkg::*;

	md_state_e            state_q;
	md_state_e            state_d;
	logic [`MD_CNT_W-1:0] cnt_q;
	logic [`MD_CNT_W-1:0] cnt_d;
	logic                 div_by_zero;
	logic                 is_mult;

	assign div_by_zero = (op_b_i == '0);
	assign is_mult     = (operator_i == MD_OP_MULL) || (operator_i == MD_OP_MULH);

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		if (mult_en_i || div_en_i) begin
			case (state_q)
				MD_IDLE: begin
					cnt_d = `MD_CNT_W'(`MD_ITER_LAST);
					if (is_mult) begin
						state_d = MD_COMP;
					end else begin
						// Zero divisor skips straight to the result
						state_d = div_by_zero ? MD_FINISH : MD_ABS_A;
					end
				end
				MD_ABS_A: begin
					state_d = MD_ABS_B;
				end
				MD_ABS_B: begin
					state_d = MD_COMP;
				end
				MD_COMP: begin
					cnt_d = cnt_q - 1'b1;
					if (cnt_q == `MD_CNT_W'(1)) begin
						state_d = MD_LAST;
					end
				end
				MD_LAST: begin
					state_d = is_mult ? MD_IDLE : MD_CHANGE_SIGN;
				end
				MD_CHANGE_SIGN: begin
					state_d = MD_FINISH;
				end
				MD_FINISH: begin
					state_d = MD_IDLE;
				end
				default: begin
					state_d = MD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= MD_IDLE;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
		end
	end

	// Multiply finishes in LAST, divide in FINISH
	assign valid_o = (state_q == MD_FINISH) || ((state_q == MD_LAST) && is_mult);

	assign state_o    = state_q;
	assign iter_cnt_o = cnt_q;

endmodule

// ==== md_shared_adder.sv ====
`timescale 1ns/1ps
`include "md_consts.svh"

module md_shared_adder (
	input  md_pkg::md_state_e     state_i,
	input  md_pkg::md_op_e        operator_i,
	input  logic [`MD_WIDTH-1:0]  op_a_i,
	input  logic [`MD_WIDTH-1:0]  op_b_i,
	input  logic [`MD_WIDTH:0]    accum_i,
	input  logic [`MD_WIDTH:0]    op_a_shift_i,
	input  logic [`MD_WIDTH:0]    op_b_shift_i,
	output logic [`MD_WIDTH+1:0]  adder_ext_o
);
	import md_pkg::*;

	logic [`MD_WIDTH-1:0] b_0;
	logic [`MD_WIDTH:0]   bw_pp;
	logic [`MD_WIDTH:0]   bw_last_pp;
	logic [`MD_WIDTH-1:0] neg_src;
	logic [`MD_WIDTH:0]   operand_a;
	logic [`MD_WIDTH:0]   operand_b;

	// Baugh-Wooley partial products
	assign b_0        = {`MD_WIDTH{op_b_shift_i[0]}};
	assign bw_pp      = {~(op_a_shift_i[`MD_WIDTH] & op_b_shift_i[0]),
	                     (op_a_shift_i[`MD_WIDTH-1:0] & b_0)};
	assign bw_last_pp = {(op_a_shift_i[`MD_WIDTH] & op_b_shift_i[0]),
	                     ~(op_a_shift_i[`MD_WIDTH-1:0] & b_0)};

	// Value to negate in the sign steps
	always_comb begin
		case (state_i)
			MD_ABS_A:       neg_src = op_a_i;
			MD_CHANGE_SIGN: neg_src = accum_i[`MD_WIDTH-1:0];
			default:        neg_src = op_b_i;
		endcase
	end

	// For divide, the low bit of each operand forms the carry-in
	always_comb begin
		operand_a = accum_i;
		case (operator_i)
			MD_OP_MULL: operand_b = bw_pp;
			MD_OP_MULH: operand_b = (state_i == MD_LAST) ? bw_last_pp : bw_pp;
			default: begin
				if ((state_i == MD_ABS_A) || (state_i == MD_ABS_B) ||
				    (state_i == MD_CHANGE_SIGN)) begin
					operand_a = {{`MD_WIDTH{1'b0}}, 1'b1};
					operand_b = {~neg_src, 1'b1};
				end else begin
					// Trial subtraction of the divisor
					operand_a = {accum_i[`MD_WIDTH-1:0], 1'b1};
					operand_b = {~op_b_shift_i[`MD_WIDTH-1:0], 1'b1};
				end
			end
		endcase
	end

	assign adder_ext_o = {1'b0, operand_a} + {1'b0, operand_b};

endmodule

// ==== md_datapath.sv ====
`timescale 1ns/1ps
`include "md_consts.svh"

module md_datapath (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  md_pkg::md_state_e     state_i,
	input  logic [`MD_CNT_W-1:0]  iter_cnt_i,
	input  md_pkg::md_op_e        operator_i,
	input  logic [1:0]            signed_mode_i,
	input  logic [`MD_WIDTH-1:0]  op_a_i,
	input  logic [`MD_WIDTH-1:0]  op_b_i,
	input  logic [`MD_WIDTH+1:0]  adder_ext_i,
	input  logic                  div_en_i,
	output logic [`MD_WIDTH:0]    accum_o,
	output logic [`MD_WIDTH:0]    op_a_shift_o,
	output logic [`MD_WIDTH:0]    op_b_shift_o,
	output logic [`MD_WIDTH-1:0]  result_o
);
	import md_pkg::*;

	logic [`MD_WIDTH:0]   accum_q;
	logic [`MD_WIDTH:0]   accum_d;
	logic [`MD_WIDTH:0]   op_a_shift_q;
	logic [`MD_WIDTH:0]   op_a_shift_d;
	logic [`MD_WIDTH:0]   op_b_shift_q;
	logic [`MD_WIDTH:0]   op_b_shift_d;
	logic [`MD_WIDTH-1:0] numer_q;
	logic [`MD_WIDTH-1:0] numer_d;
	logic [`MD_WIDTH:0]   res_adder_l;
	logic [`MD_WIDTH:0]   res_adder_h;
	logic [`MD_WIDTH-1:0] adder_neg;
	logic [`MD_WIDTH:0]   op_a_ext;
	logic [`MD_WIDTH:0]   op_b_ext;
	logic                 sign_a;
	logic                 sign_b;
	logic                 b0;
	logic [`MD_WIDTH:0]   one_shift;
	logic [`MD_CNT_W-1:0] cnt_m1;
	logic                 is_greater_equal;
	logic [`MD_WIDTH:0]   next_remainder;
	logic [`MD_WIDTH:0]   next_quotient;

	assign res_adder_l = adder_ext_i[`MD_WIDTH:0];
	assign res_adder_h = adder_ext_i[`MD_WIDTH+1:1];
	assign adder_neg   = adder_ext_i[`MD_WIDTH:1];

	assign sign_a   = op_a_i[`MD_WIDTH-1] & signed_mode_i[0];
	assign sign_b   = op_b_i[`MD_WIDTH-1] & signed_mode_i[1];
	assign op_a_ext = {sign_a, op_a_i};
	assign op_b_ext = {sign_b, op_b_i};
	assign b0       = op_b_i[0];

	////////////////////////////////////////////////////////////////////////////
	// Restoring division step
	////////////////////////////////////////////////////////////////////////////

	assign cnt_m1    = iter_cnt_i - 1'b1;
	assign one_shift = {{`MD_WIDTH{1'b0}}, 1'b1} << iter_cnt_i;

	// Compare on sign bits first, then on the trial difference
	assign is_greater_equal = (accum_q[`MD_WIDTH-1] == op_b_shift_q[`MD_WIDTH-1]) ?
	                          ~res_adder_h[`MD_WIDTH-1] : accum_q[`MD_WIDTH-1];
	assign next_remainder   = is_greater_equal ? res_adder_h : accum_q;
	assign next_quotient    = is_greater_equal ? (op_a_shift_q | one_shift) : op_a_shift_q;

	always_comb begin
		accum_d      = accum_q;
		op_a_shift_d = op_a_shift_q;
		op_b_shift_d = op_b_shift_q;
		numer_d      = numer_q;
		case (state_i)
			MD_IDLE: begin
				case (operator_i)
					MD_OP_MULL: begin
						op_a_shift_d = op_a_ext << 1;
						op_b_shift_d = op_b_ext >> 1;
						accum_d      = {~(op_a_ext[`MD_WIDTH] & b0),
						                (op_a_ext[`MD_WIDTH-1:0] & {`MD_WIDTH{b0}})};
					end
					MD_OP_MULH: begin
						op_a_shift_d = op_a_ext;
						op_b_shift_d = op_b_ext >> 1;
						accum_d      = {1'b1, ~(op_a_ext[`MD_WIDTH] & b0),
						                (op_a_ext[`MD_WIDTH-1:1] & {(`MD_WIDTH-1){b0}})};
					end
					// Seeds double as the divide-by-zero results
					MD_OP_DIV: accum_d = '1;
					default:   accum_d = op_a_ext;
				endcase
			end
			MD_ABS_A: begin
				op_a_shift_d = '0;
				numer_d      = sign_a ? adder_neg : op_a_i;
			end
			MD_ABS_B: begin
				accum_d      = {{`MD_WIDTH{1'b0}}, numer_q[`MD_WIDTH-1]};
				op_b_shift_d = {1'b0, (sign_b ? adder_neg : op_b_i)};
			end
			MD_COMP: begin
				case (operator_i)
					MD_OP_MULL: begin
						accum_d      = res_adder_l;
						op_a_shift_d = op_a_shift_q << 1;
						op_b_shift_d = op_b_shift_q >> 1;
					end
					MD_OP_MULH: begin
						accum_d      = res_adder_h;
						op_b_shift_d = op_b_shift_q >> 1;
					end
					default: begin
						accum_d      = {next_remainder[`MD_WIDTH-1:0], numer_q[cnt_m1]};
						op_a_shift_d = next_quotient;
					end
				endcase
			end
			MD_LAST: begin
				case (operator_i)
					MD_OP_DIV: accum_d = next_quotient;
					MD_OP_REM: accum_d = {1'b0, next_remainder[`MD_WIDTH-1:0]};
					default:   accum_d = res_adder_l;
				endcase
			end
			MD_CHANGE_SIGN: begin
				// Quotient sign from both operands, remainder follows the dividend
				if (operator_i == MD_OP_DIV) begin
					accum_d = (sign_a ^ sign_b) ? {1'b0, adder_neg} : accum_q;
				end else begin
					accum_d = sign_a ? {1'b0, adder_neg} : accum_q;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			accum_q      <= '0;
			op_a_shift_q <= '0;
			op_b_shift_q <= '0;
			numer_q      <= '0;
		end else begin
			accum_q      <= accum_d;
			op_a_shift_q <= op_a_shift_d;
			op_b_shift_q <= op_b_shift_d;
			numer_q      <= numer_d;
		end
	end

	assign accum_o      = accum_q;
	assign op_a_shift_o = op_a_shift_q;
	assign op_b_shift_o = op_b_shift_q;
	assign result_o     = div_en_i ? accum_q[`MD_WIDTH-1:0] : res_adder_l[`MD_WIDTH-1:0];

endmodule

// ==== md_slow_top.sv ====
`timescale 1ns/1ps
`include "md_consts.svh"

module md_slow_top (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  mult_en_i,
	input  logic                  div_en_i,
	input  md_pkg::md_op_e        operator_i,
	input  logic [1:0]            signed_mode_i,
	input  logic [`MD_WIDTH-1:0]  op_a_i,
	input  logic [`MD_WIDTH-1:0]  op_b_i,
	output logic [`MD_WIDTH-1:0]  result_o,
	output logic                  valid_o
);
	import md_pkg::*;

	md_state_e            state;
	logic [`MD_CNT_W-1:0] iter_cnt;
	logic [`MD_WIDTH:0]   accum;
	logic [`MD_WIDTH:0]   op_a_shift;
	logic [`MD_WIDTH:0]   op_b_shift;
	logic [`MD_WIDTH+1:0] adder_ext;

	md_fsm u_fsm (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.mult_en_i  (mult_en_i),
		.div_en_i   (div_en_i),
		.operator_i (operator_i),
		.op_b_i     (op_b_i),
		.state_o    (state),
		.iter_cnt_o (iter_cnt),
		.valid_o    (valid_o)
	);

	md_shared_adder u_adder (
		.state_i      (state),
		.operator_i   (operator_i),
		.op_a_i       (op_a_i),
		.op_b_i       (op_b_i),
		.accum_i      (accum),
		.op_a_shift_i (op_a_shift),
		.op_b_shift_i (op_b_shift),
		.adder_ext_o  (adder_ext)
	);

	md_datapath u_datapath (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.state_i       (state),
		.iter_cnt_i    (iter_cnt),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.adder_ext_i   (adder_ext),
		.div_en_i      (div_en_i),
		.accum_o       (accum),
		.op_a_shift_o  (op_a_shift),
		.op_b_shift_o  (op_b_shift),
		.result_o      (result_o)
	);

endmodule

// ==== md_slow_assert.sv ====
`timescale 1ns/1ps

module md_slow_assert (
	input logic clk_i,
	input logic rst_ni,
	input logic mult_en_i,
	input logic div_en_i,
	input logic valid_o
);

	int fail_cnt = 0;

	// No result while the unit is held in reset
	valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
		else begin
			$error("valid_o high during reset");
			fail_cnt++;
		end

	// Result is a single-cycle pulse
	valid_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
		valid_o |=> !valid_o)
		else begin
			$error("valid_o high in two consecutive cycles");
			fail_cnt++;
		end

	valid_needs_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
		valid_o |-> (mult_en_i || div_en_i))
		else begin
			$error("valid_o high with both enables low");
			fail_cnt++;
		end

endmodule

// ==== tb_md_slow.sv ====
`timescale 1ns/1ps

module tb_md_slow;
	import md_pkg::*;

	localparam int NUM_DIRECTED = 21;
	localparam int NUM_RANDOM   = 40;
	localparam int TIMEOUT_CYC  = 60;

	typedef struct packed {
		md_op_e      op;
		logic [1:0]  mode;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp;
	} entry_t;

	logic        clk_i;
	logic        rst_ni;
	logic        mult_en_i;
	logic        div_en_i;
	md_op_e      operator_i;
	logic [1:0]  signed_mode_i;
	logic [31:0] op_a_i;
	logic [31:0] op_b_i;
	logic [31:0] result_o;
	logic        valid_o;

	int errors;
	int tests;
	bit timed_out;

	// op, signed mode, A, B, expected result
	entry_t directed [NUM_DIRECTED] = '{
		'{MD_OP_MULL, 2'b11, 32'h00000007, 32'h00000006, 32'h0000002a},
		'{MD_OP_MULL, 2'b11, 32'hfffffffd, 32'h00000005, 32'hfffffff1},
		'{MD_OP_MULH, 2'b11, 32'h80000000, 32'h80000000, 32'h40000000},
		'{MD_OP_MULH, 2'b11, 32'hffffffff, 32'h00000002, 32'hffffffff},
		'{MD_OP_MULH, 2'b01, 32'hffffffff, 32'hffffffff, 32'hffffffff},
		'{MD_OP_MULH, 2'b00, 32'hffffffff, 32'hffffffff, 32'hfffffffe},
		'{MD_OP_MULH, 2'b00, 32'h00010000, 32'h00010000, 32'h00000001},
		'{MD_OP_DIV,  2'b11, 32'h00000064, 32'h00000007, 32'h0000000e},
		'{MD_OP_REM,  2'b11, 32'h00000064, 32'h00000007, 32'h00000002},
		'{MD_OP_DIV,  2'b11, 32'hffffff9c, 32'h00000007, 32'hfffffff2},
		'{MD_OP_REM,  2'b11, 32'hffffff9c, 32'h00000007, 32'hfffffffe},
		'{MD_OP_DIV,  2'b11, 32'h00000064, 32'hfffffff9, 32'hfffffff2},
		'{MD_OP_REM,  2'b11, 32'h00000064, 32'hfffffff9, 32'h00000002},
		'{MD_OP_DIV,  2'b00, 32'hffffffff, 32'h00000002, 32'h7fffffff},
		'{MD_OP_REM,  2'b00, 32'hffffffff, 32'h00000010, 32'h0000000f},
		// Signed overflow case
		'{MD_OP_DIV,  2'b11, 32'h80000000, 32'hffffffff, 32'h80000000},
		'{MD_OP_REM,  2'b11, 32'h80000000, 32'hffffffff, 32'h00000000},
		// Zero divisor
		'{MD_OP_DIV,  2'b11, 32'h12345678, 32'h00000000, 32'hffffffff},
		'{MD_OP_REM,  2'b11, 32'h12345678, 32'h00000000, 32'h12345678},
		'{MD_OP_DIV,  2'b00, 32'h00000005, 32'h00000000, 32'hffffffff},
		'{MD_OP_REM,  2'b00, 32'h87654321, 32'h00000000, 32'h87654321}
	};

	md_slow_top DUT (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.mult_en_i     (mult_en_i),
		.div_en_i      (div_en_i),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.result_o      (result_o),
		.valid_o       (valid_o)
	);

	bind md_slow_top md_slow_assert u_assert (.*);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model, RISC-V M semantics on 64-bit values
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] expected_result(md_op_e op, logic [1:0] mode,
	                                                logic [31:0] a, logic [31:0] b);
		logic [63:0] ext_a;
		logic [63:0] ext_b;
		logic [63:0] prod;
		longint      num;
		longint      den;
		ext_a = {{32{a[31] & mode[0]}}, a};
		ext_b = {{32{b[31] & mode[1]}}, b};
		prod  = ext_a * ext_b;
		num   = longint'(ext_a);
		den   = longint'(ext_b);
		case (op)
			MD_OP_MULL: return prod[31:0];
			MD_OP_MULH: return prod[63:32];
			MD_OP_DIV:  return (b == '0) ? 32'hffffffff : 32'(num / den);
			default:    return (b == '0) ? a : 32'(num % den);
		endcase
	endfunction

	task automatic check_idle(input int cycles);
		int err_start;
		err_start = errors;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk_i);
			assert (valid_o === 1'b0) else begin
				$display("mismatch valid_o idle cycle %0d: got 0x%0h expected 0x0", i, valid_o);
				errors++;
			end
		end
		$display("test %0d idle after reset: %s", tests, (errors == err_start) ? "ok" : "FAILED");
		tests++;
	endtask

	task automatic apply_entry(input entry_t e);
		int          cycle;
		int          exp_cycle;
		int          err_start;
		logic        seen;
		logic        is_mul;
		logic [31:0] got;
		cycle     = 1;
		seen      = 1'b0;
		err_start = errors;
		is_mul    = (e.op == MD_OP_MULL) || (e.op == MD_OP_MULH);
		exp_cycle = is_mul ? 33 : ((e.b == '0) ? 2 : 37);
		@(negedge clk_i);
		operator_i    = e.op;
		signed_mode_i = e.mode;
		op_a_i        = e.a;
		op_b_i        = e.b;
		mult_en_i     = is_mul;
		div_en_i      = !is_mul;
		while (!seen && cycle <= TIMEOUT_CYC) begin
			@(negedge clk_i);
			cycle++;
			seen = valid_o;
		end
		if (!seen) begin
			$display("test %0d: valid_o never came within %0d cycles", tests, TIMEOUT_CYC);
			errors++;
			timed_out = 1'b1;
		end else begin
			got = result_o;
			assert (got === e.exp) else begin
				$display("mismatch result_o test %0d: got 0x%08h expected 0x%08h",
				         tests, got, e.exp);
				errors++;
			end
			assert (cycle == exp_cycle) else begin
				$display("mismatch valid_o cycle test %0d: got 0x%0h expected 0x%0h",
				         tests, cycle, exp_cycle);
				errors++;
			end
			// Hold the enable through the valid edge so the FSM returns to idle
			@(negedge clk_i);
		end
		mult_en_i = 1'b0;
		div_en_i  = 1'b0;
		$display("test %0d %s mode %b a=%08h b=%08h: %s", tests, e.op.name(), e.mode,
		         e.a, e.b, (errors == err_start) ? "ok" : "FAILED");
		tests++;
	endtask

	initial begin
		entry_t rnd;
		int     pick;
		errors        = 0;
		tests         = 0;
		timed_out     = 1'b0;
		void'($urandom(57));
		rst_ni        = 1'b0;
		mult_en_i     = 1'b0;
		div_en_i      = 1'b0;
		operator_i    = MD_OP_MULL;
		signed_mode_i = 2'b00;
		op_a_i        = '0;
		op_b_i        = '0;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;

		check_idle(8);
		for (int i = 0; i < NUM_DIRECTED; i++) begin
			if (timed_out) break;
			apply_entry(directed[i]);
		end

		// Random operands, sometimes a short or zero divisor
		for (int i = 0; i < NUM_RANDOM; i++) begin
			if (timed_out) break;
			rnd.op = md_op_e'($urandom % 4);
			pick   = $urandom % 3;
			if ((rnd.op == MD_OP_MULL) || (rnd.op == MD_OP_MULH)) begin
				rnd.mode = (pick == 0) ? 2'b00 : ((pick == 1) ? 2'b01 : 2'b11);
			end else begin
				rnd.mode = (pick == 0) ? 2'b00 : 2'b11;
			end
			rnd.a = $urandom;
			rnd.b = $urandom;
			if ($urandom % 2) rnd.b = rnd.b >> ($urandom % 32);
			if ($urandom % 10 == 0) rnd.b = '0;
			rnd.exp = expected_result(rnd.op, rnd.mode, rnd.a, rnd.b);
			apply_entry(rnd);
		end

		errors += DUT.u_assert.fail_cnt;
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
md_pkg.sv
md_fsm.sv
md_shared_adder.sv
md_datapath.sv
md_slow_top.sv
md_slow_assert.sv
tb_md_slow.sv

// ==== Makefile ====
.PHONY: all lint clean

all: obj_dir/Vtb_md_slow
	./obj_dir/Vtb_md_slow +verilator+error+limit+100 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

obj_dir/Vtb_md_slow: sim.f md_consts.svh md_pkg.sv md_fsm.sv md_shared_adder.sv \
		md_datapath.sv md_slow_top.sv md_slow_assert.sv tb_md_slow.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_md_slow -f sim.f

lint:
	verilator --lint-only --timing -Wall --top-module tb_md_slow -f sim.f

clean:
	rm -rf obj_dir sim.log
